//--- rtl/fetch_pkg.sv
package fetch_pkg;

  localparam int ADDR_W = 32;

  // byte address of one fetch, always word aligned in this design
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [31:0] inst_t;

  // what the decode stage gets for every fetched word
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_pkt_t;

  // cache line geometry
  // the refill FSM is written for exactly two beats per line
  localparam int LINE_WORDS = 2;

  // byte offset bits inside one line
  localparam int OFFSET_W = 3;

  // byte offset bits inside one word
  localparam int WORD_OFFSET_W = 2;

  // bits that select a word inside a line
  localparam int WORD_SEL_W = OFFSET_W - WORD_OFFSET_W;

  // byte distance between consecutive fetches
  localparam addr_t PC_STEP = 32'd4;

endpackage

//--- rtl/fetch_req_if.sv
interface fetch_req_if;
  import fetch_pkg::*;

  logic  valid;
  logic  ready;
  addr_t pc;
  // path tag, toggled by the sequencer on every redirect
  logic  epoch;

  modport src (
    output valid,
    output pc,
    output epoch,
    input  ready
  );

  modport snk (
    input  valid,
    input  pc,
    input  epoch,
    output ready
  );

endinterface

//--- rtl/fetch_rsp_if.sv
interface fetch_rsp_if;
  import fetch_pkg::*;

  logic       valid;
  logic       ready;
  fetch_pkt_t pkt;
  logic       epoch;
  // one cycle wide, comes from the sequencer after a redirect
  logic       flush;

  modport src (
    output valid,
    output pkt,
    output epoch,
    input  ready,
    input  flush
  );

  modport snk (
    input  valid,
    input  pkt,
    input  epoch,
    input  flush,
    output ready
  );

  modport ctl (
    output flush
  );

endinterface

//--- rtl/fetch_pc_seq.sv
module fetch_pc_seq #(
  parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  fetch_req_if.src         req,
  fetch_rsp_if.ctl         ctl
);
  import fetch_pkg::*;

  addr_t pc_q;
  logic  epoch_q;
  logic  valid_q;
  logic  flush_q;
  logic  req_fire;
  addr_t target_pc;

  assign req_fire = req.valid && req.ready;

  // the target is forced onto a word boundary
  assign target_pc = {redirect_pc_i[ADDR_W-1:WORD_OFFSET_W], {WORD_OFFSET_W{1'b0}}};

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= RESET_PC;
      epoch_q <= 1'b0;
      valid_q <= 1'b0;
      flush_q <= 1'b0;
    end else begin
      // fetch runs ahead all the time once reset is gone
      valid_q <= 1'b1;
      flush_q <= redirect_valid_i;
      if (redirect_valid_i) begin
        // a redirect takes over even while the cache stalls us
        pc_q    <= target_pc;
        epoch_q <= ~epoch_q;
      end else if (req_fire) begin
        pc_q <= pc_q + PC_STEP;
      end
    end
  end

  assign req.valid = valid_q;
  assign req.pc    = pc_q;
  assign req.epoch = epoch_q;
  assign ctl.flush = flush_q;

  // a stalled request keeps its address and epoch unless a redirect replaced it,
  // which shows up as the flush pulse one cycle later
  a_req_stable: assert property (
    @(posedge clk) disable iff (rst)
    req.valid && !req.ready |=> $stable({req.pc, req.epoch}) || ctl.flush
  ) else $error("fetch request changed while stalled");

endmodule

//--- rtl/fetch_icache.sv
module fetch_icache #(
  parameter int ICACHE_SETS = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             invalidate_i,
  output logic             mem_arvalid_o,
  output fetch_pkg::addr_t mem_araddr_o,
  input  logic             mem_arready_i,
  input  logic             mem_rvalid_i,
  input  fetch_pkg::inst_t mem_rdata_i,
  fetch_req_if.snk         req,
  fetch_rsp_if.src         rsp
);
  import fetch_pkg::*;

  localparam int INDEX_W = $clog2(ICACHE_SETS);
  localparam int TAG_W   = ADDR_W - INDEX_W - OFFSET_W;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_BEAT0,
    ST_BEAT1,
    ST_RESP
  } state_t;

  state_t state_q;

  logic [TAG_W-1:0]     tag_mem  [ICACHE_SETS];
  inst_t                data_mem [ICACHE_SETS][LINE_WORDS];
  logic [ICACHE_SETS-1:0] line_valid_q;

  // pc and epoch of the request being served go out with the response
  addr_t req_pc_q;
  logic  req_epoch_q;
  inst_t rsp_inst_q;
  logic  rsp_valid_q;

  // set when the pending refill must not answer or must not mark its line valid
  logic  drop_q;
  logic  inval_seen_q;

  logic                  req_fire;
  logic                  req_hit;
  logic [INDEX_W-1:0]    req_idx;
  logic [TAG_W-1:0]      req_tag;
  logic [WORD_SEL_W-1:0] req_word;
  logic [INDEX_W-1:0]    refill_idx;
  logic [TAG_W-1:0]      refill_tag;
  logic [WORD_SEL_W-1:0] refill_word;

  assign req_idx  = req.pc[OFFSET_W +: INDEX_W];
  assign req_tag  = req.pc[ADDR_W-1 -: TAG_W];
  assign req_word = req.pc[OFFSET_W-1:WORD_OFFSET_W];

  assign refill_idx  = req_pc_q[OFFSET_W +: INDEX_W];
  assign refill_tag  = req_pc_q[ADDR_W-1 -: TAG_W];
  assign refill_word = req_pc_q[OFFSET_W-1:WORD_OFFSET_W];

  assign req_hit = line_valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

  // a new request is only taken when the response slot frees up this cycle
  assign req.ready = (state_q == ST_IDLE) && (!rsp_valid_q || rsp.ready);
  assign req_fire  = req.valid && req.ready;

  assign mem_arvalid_o = (state_q == ST_ADDR);
  assign mem_araddr_o  = {req_pc_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  assign rsp.valid = rsp_valid_q;
  assign rsp.epoch = req_epoch_q;
  assign rsp.pkt   = fetch_pkt_t'{pc: req_pc_q, inst: rsp_inst_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= ST_IDLE;
      rsp_valid_q  <= 1'b0;
      line_valid_q <= '0;
      drop_q       <= 1'b0;
      inval_seen_q <= 1'b0;
    end else begin
      if (rsp.valid && rsp.ready) begin
        rsp_valid_q <= 1'b0;
      end
      if (rsp.flush) begin
        rsp_valid_q <= 1'b0;
      end
      case (state_q)
        ST_IDLE: begin
          if (req_fire) begin
            if (req_hit) begin
              rsp_valid_q <= 1'b1;
            end else begin
              state_q      <= ST_ADDR;
              drop_q       <= 1'b0;
              inval_seen_q <= 1'b0;
            end
          end
        end
        ST_ADDR: begin
          if (mem_arready_i) begin
            state_q <= ST_BEAT0;
          end
        end
        ST_BEAT0: begin
          if (mem_rvalid_i) begin
            state_q <= ST_BEAT1;
          end
        end
        ST_BEAT1: begin
          if (mem_rvalid_i) begin
            state_q <= ST_RESP;
            if (!inval_seen_q) begin
              line_valid_q[refill_idx] <= 1'b1;
            end
          end
        end
        ST_RESP: begin
          state_q     <= ST_IDLE;
          rsp_valid_q <= !(drop_q || rsp.flush);
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
      if (rsp.flush && state_q != ST_IDLE) begin
        drop_q <= 1'b1;
      end
      // all lines go at once as for fence.i
      if (invalidate_i) begin
        line_valid_q <= '0;
        if (state_q != ST_IDLE) begin
          inval_seen_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_pc_q    <= req.pc;
      req_epoch_q <= req.epoch;
      rsp_inst_q  <= data_mem[req_idx][req_word];
    end
    if (state_q == ST_BEAT0 && mem_rvalid_i) begin
      data_mem[refill_idx][0] <= mem_rdata_i;
    end
    if (state_q == ST_BEAT1 && mem_rvalid_i) begin
      data_mem[refill_idx][1] <= mem_rdata_i;
      tag_mem[refill_idx]     <= refill_tag;
    end
    // the refilled word is read back from the array
    if (state_q == ST_RESP) begin
      rsp_inst_q <= data_mem[refill_idx][refill_word];
    end
  end

  // the word select inside a line assumes word aligned fetch addresses
  a_req_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    req_fire |-> req.pc[WORD_OFFSET_W-1:0] == '0
  ) else $error("fetch address not word aligned");

  a_rvalid_in_refill: assert property (
    @(posedge clk) disable iff (rst)
    mem_rvalid_i |-> (state_q == ST_BEAT0 || state_q == ST_BEAT1)
  ) else $error("read beat arrived with no refill pending");

  a_arvalid_held: assert property (
    @(posedge clk) disable iff (rst)
    mem_arvalid_o && !mem_arready_i |=> mem_arvalid_o && $stable(mem_araddr_o)
  ) else $error("read request dropped before arready");

endmodule

//--- rtl/fetch_out_buf.sv
module fetch_out_buf (
  input  logic             clk,
  input  logic             rst,
  fetch_rsp_if.snk         in,
  output logic             dec_valid_o,
  output fetch_pkg::addr_t dec_pc_o,
  output fetch_pkg::inst_t dec_inst_o,
  input  logic             dec_ready_i
);
  import fetch_pkg::*;

  fetch_pkt_t buf_q [2];
  fetch_pkt_t head;
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  // our copy of the current path epoch, toggled on every flush
  logic       epoch_q;
  logic       push;
  logic       pop;

  // room for one more keeps a packet in flight safe when decode stalls
  assign in.ready = (count_q != 2'd2);

  // old path packets are taken off the link and thrown away
  assign push = in.valid && in.ready && (in.epoch == epoch_q) && !in.flush;
  assign pop  = dec_valid_o && dec_ready_i;

  assign head        = buf_q[rd_ptr_q];
  assign dec_valid_o = (count_q != 2'd0);
  assign dec_pc_o    = head.pc;
  assign dec_inst_o  = head.inst;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      epoch_q  <= 1'b0;
    end else if (in.flush) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
      epoch_q  <= ~epoch_q;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      buf_q[wr_ptr_q] <= in.pkt;
    end
  end

  a_dec_hold: assert property (
    @(posedge clk) disable iff (rst)
    dec_valid_o && !dec_ready_i && !in.flush |=>
      dec_valid_o && $stable({dec_pc_o, dec_inst_o})
  ) else $error("decode packet changed under back-pressure");

endmodule

//--- rtl/fetch_top.sv
module fetch_top #(
  parameter int               ICACHE_SETS = 4,
  parameter fetch_pkg::addr_t RESET_PC    = 32'h0000_1000
) (
  input  logic             clk,
  input  logic             rst,

  // redirect and fence.i from the rest of the core
  input  logic             redirect_valid_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  logic             invalidate_i,

  // instruction memory read bus
  output logic             mem_arvalid_o,
  output fetch_pkg::addr_t mem_araddr_o,
  input  logic             mem_arready_i,
  input  logic             mem_rvalid_i,
  input  fetch_pkg::inst_t mem_rdata_i,

  // toward decode
  output logic             dec_valid_o,
  output fetch_pkg::addr_t dec_pc_o,
  output fetch_pkg::inst_t dec_inst_o,
  input  logic             dec_ready_i
);

  fetch_req_if req_if ();
  fetch_rsp_if rsp_if ();

  fetch_pc_seq #(
    .RESET_PC (RESET_PC)
  ) i_pc_seq (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .req              (req_if.src),
    .ctl              (rsp_if.ctl)
  );

  fetch_icache #(
    .ICACHE_SETS (ICACHE_SETS)
  ) i_icache (
    .clk           (clk),
    .rst           (rst),
    .invalidate_i  (invalidate_i),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arready_i (mem_arready_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .req           (req_if.snk),
    .rsp           (rsp_if.src)
  );

  fetch_out_buf i_out_buf (
    .clk         (clk),
    .rst         (rst),
    .in          (rsp_if.snk),
    .dec_valid_o (dec_valid_o),
    .dec_pc_o    (dec_pc_o),
    .dec_inst_o  (dec_inst_o),
    .dec_ready_i (dec_ready_i)
  );

endmodule

//--- tb/fetch_tb.sv
module fetch_tb;
  import fetch_pkg::*;

  localparam addr_t RESET_PC = 32'h0000_1000;
  localparam int MAX_STEPS = 64;

  logic  clk = 1'b0;
  logic  rst;
  logic  redirect_valid_i;
  addr_t redirect_pc_i;
  logic  invalidate_i;
  logic  mem_arvalid_o;
  addr_t mem_araddr_o;
  logic  mem_arready_i;
  logic  mem_rvalid_i;
  inst_t mem_rdata_i;
  logic  dec_valid_o;
  addr_t dec_pc_o;
  inst_t dec_inst_o;
  logic  dec_ready_i;

  logic [31:0] lcg_state = 32'hbb61;
  int    errors = 0;
  int    checks = 0;
  int    packets = 0;
  int    reads = 0;
  int    duty = 100;
  addr_t model_pc = RESET_PC;
  logic  mem_busy = 1'b0;
  logic  in_redirect = 1'b0;
  logic  held_valid = 1'b0;
  addr_t held_pc;
  inst_t held_inst;
  longint budget = 0;
  logic  budget_set = 1'b0;

  // trace steps are read in full before the run starts
  int          n_steps = 0;
  int          step_id [MAX_STEPS];
  logic [63:0] step_cmd [MAX_STEPS];
  logic [31:0] step_op [MAX_STEPS];
  int          step_exp [MAX_STEPS];

  fetch_top #(
    .ICACHE_SETS (4),
    .RESET_PC    (RESET_PC)
  ) i_dut (
    .clk              (clk),
    .rst              (rst),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .invalidate_i     (invalidate_i),
    .mem_arvalid_o    (mem_arvalid_o),
    .mem_araddr_o     (mem_araddr_o),
    .mem_arready_i    (mem_arready_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .dec_valid_o      (dec_valid_o),
    .dec_pc_o         (dec_pc_o),
    .dec_inst_o       (dec_inst_o),
    .dec_ready_i      (dec_ready_i)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  // memory content is the address with its upper half inverted and xor a fixed constant
  function automatic inst_t mem_word(input addr_t a);
    return {~a[31:16], a[15:0]} ^ 32'h0000_0013;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one line read with random arready delay and random gaps between beats
  task automatic serve_read();
    addr_t base;
    mem_busy = 1'b1;
    base = mem_araddr_o;
    @(posedge clk);
    #10;
    repeat (lcg_next() % 3) begin
      @(posedge clk);
      #10;
    end
    mem_arready_i = 1'b1;
    @(posedge clk);
    #10;
    mem_arready_i = 1'b0;
    for (int b = 0; b < LINE_WORDS; b++) begin
      repeat (lcg_next() % 3) begin
        mem_rvalid_i = 1'b0;
        @(posedge clk);
        #10;
      end
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = mem_word(base + 4 * b);
      @(posedge clk);
      #10;
    end
    mem_rvalid_i = 1'b0;
    mem_busy = 1'b0;
  endtask

  initial begin
    forever begin
      @(negedge clk);
      if (!rst && mem_arvalid_o) begin
        serve_read();
      end
    end
  end

  // scoreboard and monitors sample at the falling edge, where all signals are settled
  always @(negedge clk) begin
    if (rst) begin
      check_value("mem_arvalid_o", mem_arvalid_o, 0);
      check_value("dec_valid_o", dec_valid_o, 0);
    end else begin
      if (mem_arvalid_o && mem_arready_i) begin
        reads++;
        check_value("mem_araddr_o[2:0]", mem_araddr_o[OFFSET_W-1:0], 0);
      end
      if (held_valid && !in_redirect) begin
        check_value("dec_valid_o", dec_valid_o, 1);
        check_value("dec_pc_o", dec_pc_o, held_pc);
        check_value("dec_inst_o", dec_inst_o, held_inst);
      end
      if (dec_valid_o && dec_ready_i) begin
        check_value("dec_pc_o", dec_pc_o, model_pc);
        check_value("dec_inst_o", dec_inst_o, mem_word(model_pc));
        model_pc = model_pc + 4;
        packets++;
      end
      held_valid = dec_valid_o && !dec_ready_i;
      held_pc    = dec_pc_o;
      held_inst  = dec_inst_o;
    end
  end

  task automatic run_packets(input int n);
    int target;
    target = packets + n;
    while (packets < target) begin
      @(posedge clk);
      #10;
      dec_ready_i = (lcg_next() % 100) < duty;
    end
    dec_ready_i = 1'b0;
  endtask

  // with decode stalled the pipe fills and stops, then reads are counted
  task automatic settle();
    int quiet;
    quiet = 0;
    while (quiet < 40) begin
      @(negedge clk);
      if (mem_busy || mem_arvalid_o) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
  endtask

  task automatic redirect_to(input addr_t target);
    in_redirect = 1'b1;
    @(posedge clk);
    #10;
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    model_pc         = {target[31:2], 2'b00};
    @(posedge clk);
    #10;
    redirect_valid_i = 1'b0;
    repeat (2) @(posedge clk);
    #10;
    in_redirect = 1'b0;
  endtask

  task automatic pulse_invalidate();
    @(posedge clk);
    #10;
    invalidate_i = 1'b1;
    @(posedge clk);
    #10;
    invalidate_i = 1'b0;
  endtask

  function automatic void load_trace();
    int    fd;
    string line;
    fd = $fopen("tb/fetch_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file tb/fetch_trace.txt");
      return;
    end
    while (!$feof(fd) && n_steps < MAX_STEPS) begin
      line = "";
      if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
        if ($sscanf(line, "%d %s %h %d", step_id[n_steps], step_cmd[n_steps],
                    step_op[n_steps], step_exp[n_steps]) == 4) begin
          if (step_cmd[n_steps] == "run") begin
            budget += 400 * step_op[n_steps];
          end
          n_steps++;
        end
      end
    end
    $fclose(fd);
  endfunction

  initial begin
    wait (budget_set);
    repeat (budget + 2000) @(posedge clk);
    $display("watchdog expired, the fetch unit stopped delivering packets");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int cur_id;
    int err0;
    int pkt0;
    int rd0;
    int step_rd;
    rst = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i = '0;
    invalidate_i = 1'b0;
    mem_arready_i = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i = '0;
    dec_ready_i = 1'b0;
    load_trace();
    budget_set = 1'b1;
    if (n_steps == 0) begin
      $display("trace is missing or holds no steps");
      errors++;
    end
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    check_value("mem_arvalid_o", mem_arvalid_o, 0);
    check_value("dec_valid_o", dec_valid_o, 0);
    $display("test 0 done: reset, %0d errors", errors);
    cur_id = (n_steps > 0) ? step_id[0] : 0;
    err0 = errors;
    pkt0 = packets;
    rd0 = reads;
    for (int s = 0; s < n_steps; s++) begin
      if (step_id[s] != cur_id) begin
        $display("test %0d done: %0d packets, %0d reads, %0d errors", cur_id,
                 packets - pkt0, reads - rd0, errors - err0);
        cur_id = step_id[s];
        err0 = errors;
        pkt0 = packets;
        rd0 = reads;
      end
      step_rd = reads;
      if (step_cmd[s] == "duty") begin
        duty = step_op[s];
      end else if (step_cmd[s] == "redirect") begin
        redirect_to(step_op[s]);
      end else if (step_cmd[s] == "inval") begin
        pulse_invalidate();
      end else if (step_cmd[s] == "run") begin
        run_packets(step_op[s]);
        settle();
        if (step_exp[s] >= 0) begin
          check_value("mem_reads", reads - step_rd, step_exp[s]);
        end
      end else begin
        $display("unknown trace command in step %0d", s);
        errors++;
      end
    end
    $display("test %0d done: %0d packets, %0d reads, %0d errors", cur_id,
             packets - pkt0, reads - rd0, errors - err0);
    $display("checks %0d, errors %0d, packets %0d, reads %0d", checks, errors,
             packets, reads);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb/fetch_trace.txt
# columns: test id, command, operand in hex, expected line reads in decimal (-1 skips it)
# commands: duty (ready percent), run (packets), redirect (pc), inval (operand unused)
1 duty 64 -1
1 run 10 10
2 redirect 3004 -1
2 run 6 5
3 redirect 2000 -1
3 run 4 4
3 redirect 2004 -1
3 run 3 0
3 redirect 2000 -1
3 run 4 0
4 duty 32 -1
4 run 14 10
5 duty 64 -1
5 redirect 2000 -1
5 run 4 -1
5 inval 0 -1
5 redirect 2000 -1
5 run 4 4
6 duty 1e -1
6 redirect 1100 -1
6 run c 8

//--- src.f
rtl/fetch_pkg.sv
rtl/fetch_req_if.sv
rtl/fetch_rsp_if.sv
rtl/fetch_pc_seq.sv
rtl/fetch_icache.sv
rtl/fetch_out_buf.sv
rtl/fetch_top.sv
tb/fetch_tb.sv
